/* dv/vecCoreTb.sv */
module vecCoreTb;

    localparam int numRandom  = 60;
    localparam int numDump    = 16;
    localparam int numTail    = 8;
    localparam int progLen    = numRandom + numDump + numTail;
    localparam int cycleLimit = 4 * progLen + 40;
    localparam int memWords   = 1 << vecPkg::memAddrWidth;

    logic                          CLK;
    logic                          rstN;
    logic [vecPkg::pcWidth-1:0]    pc;
    logic [vecPkg::instrWidth-1:0] instr;
    vecPkg::memAddr                dataAddr;
    logic                          dataWrite;
    vecPkg::vecWord                dataWriteValue;
    vecPkg::vecWord                dataReadValue;

    logic [vecPkg::instrWidth-1:0] progMem [progLen];
    vecPkg::vecWord                dataMem [memWords];
    vecPkg::vecWord                dataInit [memWords];
    vecPkg::memAddr                expAddr [progLen];
    vecPkg::vecWord                expValue [progLen];
    int                            expCount;
    int                            firstStore;
    int                            storeCount = 0;
    int                            cycleCount = 0;

    vecCore i_vecCore (
        .CLK            (CLK),
        .rstN           (rstN),
        .pc             (pc),
        .instr          (instr),
        .dataAddr       (dataAddr),
        .dataWrite      (dataWrite),
        .dataWriteValue (dataWriteValue),
        .dataReadValue  (dataReadValue)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ##############################
    // Memory models

    // Past the end of the program the fetch sees nops.
    always_comb begin
        if (pc < progLen) begin
            instr = progMem[pc[6:0]];
        end else begin
            instr = '0;
        end
    end

    assign dataReadValue = dataMem[dataAddr];

    always @(posedge CLK) begin
        if (!rstN) begin
            for (int a = 0; a < memWords; a++) begin
                dataMem[a] <= dataInit[a];
            end
        end else if (dataWrite) begin
            dataMem[dataAddr] <= dataWriteValue;
        end
    end

    // ##############################
    // Compare tasks

    task automatic abortRun();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkAddr(input vecPkg::memAddr actual, input vecPkg::memAddr expected,
                             input string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is 0x%03h, expected 0x%03h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkVec(input vecPkg::vecWord actual, input vecPkg::vecWord expected,
                            input string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is %05h %05h %05h, expected %05h %05h %05h (lanes 2..0)",
                     $time, what, actual[2], actual[1], actual[0],
                     expected[2], expected[1], expected[0]);
            abortRun();
        end
    endtask

    task automatic checkPc(input logic [vecPkg::pcWidth-1:0] actual,
                           input logic [vecPkg::pcWidth-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkFlag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expected);
            abortRun();
        end
    endtask

    // ##############################
    // Program generation and model

    // Most picks land in a few registers so results get reused quickly.
    function automatic vecPkg::regAddr pickReg();
        if ($urandom % 4 == 0) begin
            return vecPkg::regAddr'($urandom % vecPkg::numRegs);
        end
        return vecPkg::regAddr'($urandom % 5);
    endfunction

    function automatic vecPkg::vecWord randomWord();
        vecPkg::vecWord w;
        for (int l = 0; l < vecPkg::numLanes; l++) begin
            w[l] = vecPkg::laneWord'($urandom);
        end
        return w;
    endfunction

    task automatic buildProgram();
        vecPkg::opcode  op;
        vecPkg::regAddr rd;
        vecPkg::regAddr ra;
        vecPkg::regAddr rb;
        vecPkg::regAddr lastRd;
        lastRd     = '0;
        firstStore = numRandom;
        for (int i = 0; i < numRandom; i++) begin
            op = vecPkg::opcode'($urandom % 8);
            rd = pickReg();
            // Half of the sources take the previous result, so loads are often used at once.
            ra = ($urandom % 2 == 0) ? lastRd : pickReg();
            rb = ($urandom % 2 == 0) ? lastRd : pickReg();
            progMem[i] = {op, rd, ra, rb, 13'($urandom)};
            if (op == vecPkg::opStore && firstStore == numRandom) begin
                firstStore = i;
            end
            if (op != vecPkg::opStore && op != vecPkg::opNop) begin
                lastRd = rd;
            end
        end
        // One store per register dumps the final state.
        for (int r = 0; r < numDump; r++) begin
            progMem[numRandom + r] = {vecPkg::opStore, 4'd0, 4'(r), 4'(r), 13'(512 + r)};
        end
        for (int i = numRandom + numDump; i < progLen; i++) begin
            progMem[i] = '0;
        end
    endtask

    function automatic vecPkg::vecWord laneMath(input vecPkg::opcode op,
                                                input vecPkg::vecWord a,
                                                input vecPkg::vecWord b);
        vecPkg::vecWord r;
        for (int l = 0; l < vecPkg::numLanes; l++) begin
            case (op)
                vecPkg::opSub: r[l] = a[l] - b[l];
                vecPkg::opAnd: r[l] = a[l] & b[l];
                default:       r[l] = a[l] + b[l];
            endcase
        end
        return r;
    endfunction

    // Runs the program in order with no timing and records every store.
    task automatic runModel();
        vecPkg::vecWord regs [vecPkg::numRegs];
        vecPkg::vecWord mem [memWords];
        vecPkg::vecWord immVec;
        vecPkg::opcode  op;
        vecPkg::regAddr rd;
        vecPkg::regAddr ra;
        vecPkg::regAddr rb;
        vecPkg::memAddr addr;
        for (int r = 0; r < vecPkg::numRegs; r++) begin
            regs[r] = '0;
        end
        for (int a = 0; a < memWords; a++) begin
            mem[a] = dataInit[a];
        end
        expCount = 0;
        for (int i = 0; i < progLen; i++) begin
            op = vecPkg::opcode'(progMem[i][27:25]);
            rd = progMem[i][24:21];
            ra = progMem[i][20:17];
            rb = progMem[i][16:13];
            for (int l = 0; l < vecPkg::numLanes; l++) begin
                immVec[l] = vecPkg::laneWord'(progMem[i][12:0]);
            end
            addr = vecPkg::memAddr'(regs[ra][0] + immVec[0]);
            case (op)
                vecPkg::opAdd, vecPkg::opSub, vecPkg::opAnd: begin
                    regs[rd] = laneMath(op, regs[ra], regs[rb]);
                end
                vecPkg::opAddImm: regs[rd] = laneMath(vecPkg::opAdd, regs[ra], immVec);
                vecPkg::opMovImm: regs[rd] = immVec;
                vecPkg::opLoad:   regs[rd] = mem[addr];
                vecPkg::opStore: begin
                    mem[addr]          = regs[rb];
                    expAddr[expCount]  = addr;
                    expValue[expCount] = regs[rb];
                    expCount++;
                end
                default: begin
                    // Nop.
                end
            endcase
        end
    endtask

    // ##############################
    // Store monitor and timeout

    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the program did not finish within %0d cycles", cycleLimit);
            abortRun();
        end else if (!rstN) begin
            if (cycleCount > 1) begin
                checkFlag(dataWrite, 1'b0, "dataWrite during reset");
            end
        end else begin
            if (pc <= firstStore) begin
                checkFlag(dataWrite, 1'b0, "dataWrite before the first store");
            end
            if (dataWrite) begin
                if (storeCount >= expCount) begin
                    $display("More stores reached the data port than the program holds");
                    abortRun();
                end else begin
                    checkAddr(dataAddr, expAddr[storeCount], "store address");
                    checkVec(dataWriteValue, expValue[storeCount], "store data");
                    storeCount = storeCount + 1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'he83a3aa4));
        rstN = 1'b0;
        for (int a = 0; a < memWords; a++) begin
            dataInit[a] = randomWord();
        end
        buildProgram();
        runModel();

        repeat (4) @(posedge CLK);
        rstN <= 1'b1;
        @(negedge CLK);
        checkPc(pc, '0, "pc after reset");

        while (pc < progLen) begin
            @(negedge CLK);
        end

        if (storeCount != expCount) begin
            $display("Only %0d of %0d stores reached the data port", storeCount, expCount);
            abortRun();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Builds the vecCore testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module vecCoreTb -o vecCoreSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/vecCoreSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^No errors$" "$logFile"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $logFile"
    exit 1
fi

/* source/controlUnit.sv */
module controlUnit (
    input  logic [vecPkg::instrWidth-1:0] instrD,
    stageCtrlIf.ctrl                      ctrl
);

    vecPkg::opcode op;

    assign op = vecPkg::opcode'(instrD[27:25]);

    always_comb begin
        ctrl.regWrite   = 1'b0;
        ctrl.memtoReg   = 1'b0;
        ctrl.memWrite   = 1'b0;
        ctrl.aluSrc     = 2'b00;
        ctrl.aluControl = vecPkg::aluAdd;
        case (op)
            vecPkg::opAdd: begin
                ctrl.regWrite = 1'b1;
            end
            vecPkg::opSub: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = vecPkg::aluSub;
            end
            vecPkg::opAnd: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = vecPkg::aluAnd;
            end
            vecPkg::opAddImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 2'b10;
            end
            // Zero plus the immediate.
            vecPkg::opMovImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 2'b11;
            end
            vecPkg::opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.memtoReg = 1'b1;
                ctrl.aluSrc   = 2'b10;
            end
            vecPkg::opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 2'b10;
            end
            default: begin
                // A nop leaves every control inactive.
            end
        endcase
    end

endmodule

/* source/dataPath.sv */
module dataPath (
    input  logic                          CLK,
    input  logic                          rstN,
    output logic [vecPkg::pcWidth-1:0]    pc,
    input  logic [vecPkg::instrWidth-1:0] instrF,
    output logic [vecPkg::instrWidth-1:0] instrD,
    stageCtrlIf.dp                        ctrl,
    hazardIf.dp                           haz,
    output vecPkg::memAddr                dataAddr,
    output logic                          dataWrite,
    output vecPkg::vecWord                dataWriteValue,
    input  vecPkg::vecWord                dataReadValue
);

    vecPkg::vecWord rd1D, rd2D, immD;
    vecPkg::vecWord rd1E, rd2E, immE;
    vecPkg::vecWord srcAFwd, srcAE, srcBE, writeDataE, aluResultE;
    vecPkg::vecWord aluResultM, writeDataM;
    vecPkg::vecWord aluResultW, readDataW, resultW;
    vecPkg::regAddr ra1E, ra2E, wa3E, wa3M, wa3W;
    vecPkg::aluOp   aluControlE;
    logic [1:0]     aluSrcE;
    logic           regWriteE, memtoRegE, memWriteE;
    logic           regWriteM, memtoRegM, memWriteM;
    logic           regWriteW, memtoRegW;

    function automatic vecPkg::vecWord pickOperand(input vecPkg::fwdSel sel,
                                                   input vecPkg::vecWord regVal,
                                                   input vecPkg::vecWord wbVal,
                                                   input vecPkg::vecWord memVal);
        case (sel)
            vecPkg::fwdWb:  return wbVal;
            vecPkg::fwdMem: return memVal;
            default:        return regVal;
        endcase
    endfunction

    // ##############################
    // Fetch and decode
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc     <= '0;
            instrD <= '0;
        end else begin
            if (!haz.stallF) pc <= pc + 1'b1;
            if (!haz.stallD) instrD <= instrF;
        end
    end

    assign haz.ra1D = instrD[20:17];
    assign haz.ra2D = instrD[16:13];

    always_comb begin
        for (int i = 0; i < vecPkg::numLanes; i++) begin
            immD[i] = vecPkg::laneWord'(instrD[vecPkg::immWidth-1:0]);
        end
    end

    registerFile u_registerFile (
        .CLK (CLK),
        .ra1 (haz.ra1D),
        .ra2 (haz.ra2D),
        .rd1 (rd1D),
        .rd2 (rd2D),
        .we  (regWriteW),
        .wa  (wa3W),
        .wd  (resultW)
    );

    // ##############################
    // Execute
    always_ff @(posedge CLK) begin
        if (!rstN || haz.flushE) begin
            regWriteE   <= 1'b0;
            memtoRegE   <= 1'b0;
            memWriteE   <= 1'b0;
            aluSrcE     <= 2'b00;
            aluControlE <= vecPkg::aluAdd;
        end else begin
            regWriteE   <= ctrl.regWrite;
            memtoRegE   <= ctrl.memtoReg;
            memWriteE   <= ctrl.memWrite;
            aluSrcE     <= ctrl.aluSrc;
            aluControlE <= ctrl.aluControl;
        end
    end

    always_ff @(posedge CLK) begin
        rd1E <= rd1D;
        rd2E <= rd2D;
        immE <= immD;
        ra1E <= haz.ra1D;
        ra2E <= haz.ra2D;
        wa3E <= instrD[24:21];
    end

    assign srcAFwd    = pickOperand(haz.forwardA, rd1E, resultW, aluResultM);
    assign writeDataE = pickOperand(haz.forwardB, rd2E, resultW, aluResultM);
    assign srcAE      = aluSrcE[0] ? '0 : srcAFwd;
    assign srcBE      = aluSrcE[1] ? immE : writeDataE;

    laneAlu u_laneAlu (
        .srcA   (srcAE),
        .srcB   (srcBE),
        .op     (aluControlE),
        .result (aluResultE)
    );

    // ##############################
    // Memory and writeback
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            regWriteM <= 1'b0;
            memtoRegM <= 1'b0;
            memWriteM <= 1'b0;
            regWriteW <= 1'b0;
            memtoRegW <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memtoRegM <= memtoRegE;
            memWriteM <= memWriteE;
            regWriteW <= regWriteM;
            memtoRegW <= memtoRegM;
        end
    end

    always_ff @(posedge CLK) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        wa3M       <= wa3E;
        aluResultW <= aluResultM;
        readDataW  <= dataReadValue;
        wa3W       <= wa3M;
    end

    assign dataAddr       = aluResultM[0][vecPkg::memAddrWidth-1:0];
    assign dataWrite      = memWriteM;
    assign dataWriteValue = writeDataM;
    assign resultW        = memtoRegW ? readDataW : aluResultW;

    assign haz.ra1E      = ra1E;
    assign haz.ra2E      = ra2E;
    assign haz.wa3E      = wa3E;
    assign haz.wa3M      = wa3M;
    assign haz.wa3W      = wa3W;
    assign haz.regWriteM = regWriteM;
    assign haz.regWriteW = regWriteW;
    assign haz.memtoRegE = memtoRegE;

endmodule

/* source/hazardIf.sv */
interface hazardIf;

    vecPkg::regAddr ra1D;
    vecPkg::regAddr ra2D;
    vecPkg::regAddr ra1E;
    vecPkg::regAddr ra2E;
    vecPkg::regAddr wa3E;
    vecPkg::regAddr wa3M;
    vecPkg::regAddr wa3W;
    logic           regWriteM;
    logic           regWriteW;
    logic           memtoRegE;

    vecPkg::fwdSel  forwardA;
    vecPkg::fwdSel  forwardB;
    logic           stallF;
    logic           stallD;
    logic           flushE;

    modport dp (
        output ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W,
        output regWriteM, regWriteW, memtoRegE,
        input  forwardA, forwardB, stallF, stallD, flushE
    );

    modport haz (
        input  ra1D, ra2D, ra1E, ra2E, wa3E, wa3M, wa3W,
        input  regWriteM, regWriteW, memtoRegE,
        output forwardA, forwardB, stallF, stallD, flushE
    );

endinterface

/* source/hazardUnit.sv */
module hazardUnit (
    input  logic CLK,
    input  logic rstN,
    hazardIf.haz haz
);

    logic loadUse;

    // The memory stage holds the younger result, so it wins over writeback.
    always_comb begin
        if (haz.regWriteM && (haz.wa3M == haz.ra1E)) begin
            haz.forwardA = vecPkg::fwdMem;
        end else if (haz.regWriteW && (haz.wa3W == haz.ra1E)) begin
            haz.forwardA = vecPkg::fwdWb;
        end else begin
            haz.forwardA = vecPkg::fwdReg;
        end
    end

    always_comb begin
        if (haz.regWriteM && (haz.wa3M == haz.ra2E)) begin
            haz.forwardB = vecPkg::fwdMem;
        end else if (haz.regWriteW && (haz.wa3W == haz.ra2E)) begin
            haz.forwardB = vecPkg::fwdWb;
        end else begin
            haz.forwardB = vecPkg::fwdReg;
        end
    end

    // Load data only exists after the memory stage, so a dependent
    // instruction in decode waits one cycle behind a bubble.
    assign loadUse = haz.memtoRegE &&
                     ((haz.wa3E == haz.ra1D) || (haz.wa3E == haz.ra2D));

    assign haz.stallF = loadUse;
    assign haz.stallD = loadUse;
    assign haz.flushE = loadUse;

    // The bubble clears the load from execute, so the stall cannot repeat.
    stallLastsOneCycle: assert property (
        @(posedge CLK) disable iff (!rstN) haz.stallD |=> !haz.stallD
    ) else $error("Load-use stall held decode for more than one cycle");

    memFwdNotLoad: assert property (
        @(posedge CLK) disable iff (!rstN)
        (haz.forwardA == vecPkg::fwdMem) && !$past(haz.flushE) |-> !$past(haz.memtoRegE)
    ) else $error("Operand A forwarded from a load still in the memory stage");

endmodule

/* source/laneAlu.sv */
module laneAlu (
    input  vecPkg::vecWord srcA,
    input  vecPkg::vecWord srcB,
    input  vecPkg::aluOp   op,
    output vecPkg::vecWord result
);

    // Each lane is sized on its own, so a carry never leaves its lane.
    always_comb begin
        for (int i = 0; i < vecPkg::numLanes; i++) begin
            case (op)
                vecPkg::aluAdd: result[i] = srcA[i] + srcB[i];
                vecPkg::aluSub: result[i] = srcA[i] - srcB[i];
                vecPkg::aluAnd: result[i] = srcA[i] & srcB[i];
                default:        result[i] = '0;
            endcase
        end
    end

endmodule

/* source/registerFile.sv */
module registerFile (
    input  logic           CLK,
    input  vecPkg::regAddr ra1,
    input  vecPkg::regAddr ra2,
    output vecPkg::vecWord rd1,
    output vecPkg::vecWord rd2,
    input  logic           we,
    input  vecPkg::regAddr wa,
    input  vecPkg::vecWord wd
);

    vecPkg::vecWord regs [vecPkg::numRegs] = '{default: '0};

    always_ff @(posedge CLK) begin
        if (we) begin
            regs[wa] <= wd;
        end
    end

    // Writeback and decode share a cycle, so decode sees the new value.
    assign rd1 = (we && (wa == ra1)) ? wd : regs[ra1];
    assign rd2 = (we && (wa == ra2)) ? wd : regs[ra2];

    writeAddrKnown: assert property (
        @(posedge CLK) we |-> !$isunknown(wa)
    ) else $error("Register write with an unknown address");

endmodule

/* source/stageCtrlIf.sv */
interface stageCtrlIf;

    logic         regWrite;
    logic         memtoReg;
    logic         memWrite;
    // Bit 0 zeroes source A, bit 1 puts the immediate on source B.
    logic [1:0]   aluSrc;
    vecPkg::aluOp aluControl;

    modport ctrl (
        output regWrite, memtoReg, memWrite, aluSrc, aluControl
    );

    modport dp (
        input regWrite, memtoReg, memWrite, aluSrc, aluControl
    );

endinterface

/* source/vecCore.sv */
module vecCore (
    input  logic                          CLK,
    input  logic                          rstN,
    output logic [vecPkg::pcWidth-1:0]    pc,
    input  logic [vecPkg::instrWidth-1:0] instr,
    output vecPkg::memAddr                dataAddr,
    output logic                          dataWrite,
    output vecPkg::vecWord                dataWriteValue,
    input  vecPkg::vecWord                dataReadValue
);

    logic [vecPkg::instrWidth-1:0] instrD;

    stageCtrlIf ctrlBus ();
    hazardIf    hazBus ();

    controlUnit u_controlUnit (
        .instrD (instrD),
        .ctrl   (ctrlBus.ctrl)
    );

    hazardUnit u_hazardUnit (
        .CLK  (CLK),
        .rstN (rstN),
        .haz  (hazBus.haz)
    );

    dataPath u_dataPath (
        .CLK            (CLK),
        .rstN           (rstN),
        .pc             (pc),
        .instrF         (instr),
        .instrD         (instrD),
        .ctrl           (ctrlBus.dp),
        .haz            (hazBus.dp),
        .dataAddr       (dataAddr),
        .dataWrite      (dataWrite),
        .dataWriteValue (dataWriteValue),
        .dataReadValue  (dataReadValue)
    );

endmodule

/* source/vecPkg.sv */
package vecPkg;

    localparam int numLanes     = 3;
    localparam int laneWidth    = 18;
    localparam int numRegs      = 16;
    localparam int memAddrWidth = 10;
    localparam int instrWidth   = 28;
    localparam int immWidth     = 13;
    localparam int pcWidth      = 32;

    typedef logic [laneWidth-1:0] laneWord;

    // Lane 0 sits in the least significant bits.
    typedef laneWord [numLanes-1:0] vecWord;

    typedef logic [$clog2(numRegs)-1:0] regAddr;
    typedef logic [memAddrWidth-1:0]    memAddr;

    // Field layout: op 27:25, rd 24:21, ra 20:17, rb 16:13, imm 12:0.
    typedef enum logic [2:0] {
        opNop    = 3'd0,
        opAdd    = 3'd1,
        opSub    = 3'd2,
        opAnd    = 3'd3,
        opAddImm = 3'd4,
        opMovImm = 3'd5,
        opLoad   = 3'd6,
        opStore  = 3'd7
    } opcode;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2
    } aluOp;

    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdWb  = 2'd1,
        fwdMem = 2'd2
    } fwdSel;

endpackage

/* sources.f */
source/vecPkg.sv
source/stageCtrlIf.sv
source/hazardIf.sv
source/controlUnit.sv
source/hazardUnit.sv
source/registerFile.sv
source/laneAlu.sv
source/dataPath.sv
source/vecCore.sv
dv/vecCoreTb.sv
